//--- common/ctrl_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// csr addresses
////////////////////////////////////////////////////////////////////////////

`define CSR_CRMD    14'h000
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_EENTRY  14'h00c

////////////////////////////////////////////////////////////////////////////
// exception causes
////////////////////////////////////////////////////////////////////////////

`define EXC_NOP     6'h3f       // no exception.
`define EXC_SLOTS   6           // cause slots per instruction.

////////////////////////////////////////////////////////////////////////////
// pause vector
////////////////////////////////////////////////////////////////////////////

// slots: pc, icache, ibuf, id, dispatch, ex, mem, wb
`define PAUSE_W     8
`define PAUSE_IBUF  2           // ibuf slot.

`endif

//--- common/pipe_pkg.sv
`include "ctrl_defs.svh"

package pipe_pkg;

    // stall requests raised by the stages
    typedef struct packed {
        logic pause_if;
        logic pause_id;
        logic pause_dispatch;
        logic pause_ex;
        logic pause_mem;
    } pause_t;

    ////////////////////////////////////////////////////////////////////////////
    // memory-stage record of the oldest instruction
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0]                  pc;
        logic [`EXC_SLOTS-1:0]        is_exception;    // one flag per slot.
        logic [`EXC_SLOTS-1:0][5:0]   exception_cause;
        logic [31:0]                  exception_addr;
        logic                         is_ertn;
        logic                         is_idle;
    } mem_ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // control outputs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                exception_flush;
        logic [`PAUSE_W-1:0] pause;           // thermometer, bit 0 is pc.
    } ctrl_t;

    typedef struct packed {
        logic [31:0] exception_new_pc;
        logic        is_interrupt;
    } ctrl_pc_t;

endpackage

//--- common/csr_pkg.sv
package csr_pkg;

    // write-back csr write, also forwarded to the control logic
    typedef struct packed {
        logic        csr_write_en;
        logic [13:0] csr_write_addr;
        logic [31:0] csr_write_data;
    } csr_push_forward_t;

    ////////////////////////////////////////////////////////////////////////////
    // write word layouts
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [27:0] rsvd;
        logic        pie;
        logic        ie;
        logic [1:0]  plv;
    } crmd_word_t;

    typedef struct packed {
        logic [18:0] rsvd;
        logic [12:0] bits;    // bit 10 reserved.
    } intr_word_t;

    typedef union packed {
        crmd_word_t crmd;
        intr_word_t intr;
    } csr_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // csr view and exception report
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] era_pc;
        logic [31:0] eentry_va;
        logic [11:0] ecfg_lie;    // bit 10 dropped.
        logic [11:0] estat_is;    // bit 10 dropped.
        logic        crmd_ie;
    } csr_view_t;

    typedef struct packed {
        logic        is_exception;
        logic        is_ertn;
        logic [5:0]  exception_cause;
        logic [31:0] exception_pc;
        logic [31:0] exception_addr;
    } exc_report_t;

    // 13-bit interrupt field to the 12-bit packing and back
    function automatic logic [11:0] pack_int(input logic [12:0] bits);
        return {bits[12:11], bits[9:0]};
    endfunction

    function automatic logic [12:0] unpack_int(input logic [11:0] packed_bits);
        return {packed_bits[11:10], 1'b0, packed_bits[9:0]};
    endfunction

endpackage

//--- csr/csr_regs.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module csr_regs (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  csr_pkg::csr_push_forward_t wb_push_i,
    input  csr_pkg::exc_report_t       exc_report_i,
    input  logic [7:0]                 int_lines_i,
    input  logic [13:0]                rd_addr_i,
    output logic [31:0]                rd_data_o,
    output csr_pkg::csr_view_t         csr_view_o
);
    import csr_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_pie;
    logic [11:0] ecfg_lie;
    logic [11:0] estat_is;
    logic [5:0]  estat_ecode;
    logic [31:0] era_pc;
    logic [31:0] eentry_va;

    csr_word_u   wr_word;
    logic [11:0] wr_int;
    logic        wr_crmd;
    logic        wr_ecfg;
    logic        wr_estat;
    logic        wr_era;
    logic        wr_eentry;

    ////////////////////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////////////////////

    assign wr_word = wb_push_i.csr_write_data;
    assign wr_int  = pack_int(wr_word.intr.bits);

    assign wr_crmd   = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_CRMD);
    assign wr_ecfg   = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_ECFG);
    assign wr_estat  = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_ESTAT);
    assign wr_era    = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_ERA);
    assign wr_eentry = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_EENTRY);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crmd_plv <= 2'b00;
            crmd_ie  <= 1'b0;
            crmd_pie <= 1'b0;
        end else if (exc_report_i.is_exception) begin
            crmd_pie <= crmd_ie;                // save and mask.
            crmd_ie  <= 1'b0;
        end else if (exc_report_i.is_ertn) begin
            crmd_ie  <= crmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= wr_word.crmd.plv;
            crmd_ie  <= wr_word.crmd.ie;
            crmd_pie <= wr_word.crmd.pie;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            era_pc <= '0;
        end else if (exc_report_i.is_exception) begin
            era_pc <= exc_report_i.exception_pc;
        end else if (wr_era) begin
            era_pc <= wb_push_i.csr_write_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ecfg_lie  <= '0;
            eentry_va <= '0;
        end else begin
            if (wr_ecfg) begin
                ecfg_lie <= wr_int;
            end
            if (wr_eentry) begin
                eentry_va <= wb_push_i.csr_write_data;
            end
        end
    end

    // hardware lines land in is[9:2], software owns the rest
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            estat_is    <= '0;
            estat_ecode <= '0;
        end else begin
            estat_is[9:2] <= int_lines_i;
            if (wr_estat) begin
                estat_is[11:10] <= wr_int[11:10];
                estat_is[1:0]   <= wr_int[1:0];
            end
            if (exc_report_i.is_exception) begin
                estat_ecode <= exc_report_i.exception_cause;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port and view
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (rd_addr_i)
            `CSR_CRMD:   rd_data_o = {28'b0, crmd_pie, crmd_ie, crmd_plv};
            `CSR_ECFG:   rd_data_o = {19'b0, unpack_int(ecfg_lie)};
            `CSR_ESTAT:  rd_data_o = {10'b0, estat_ecode, 3'b0, unpack_int(estat_is)};
            `CSR_ERA:    rd_data_o = era_pc;
            `CSR_EENTRY: rd_data_o = eentry_va;
            default:     rd_data_o = '0;         // unmodelled csrs.
        endcase
    end

    assign csr_view_o.era_pc    = era_pc;
    assign csr_view_o.eentry_va = eentry_va;
    assign csr_view_o.ecfg_lie  = ecfg_lie;
    assign csr_view_o.estat_is  = estat_is;
    assign csr_view_o.crmd_ie   = crmd_ie;

    a_exc_ertn_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(exc_report_i.is_exception && exc_report_i.is_ertn));

endmodule

//--- ctrl/exc_ctrl.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module exc_ctrl (
    input  pipe_pkg::pause_t           pause_i,
    input  pipe_pkg::mem_ctrl_t        mem_i,
    input  csr_pkg::csr_push_forward_t wb_push_i,
    input  csr_pkg::csr_view_t         csr_view_i,
    input  logic                       continue_idle_i,
    output csr_pkg::exc_report_t       exc_report_o,
    output logic                       int_pending_o,
    output pipe_pkg::ctrl_t            ctrl_o,
    output pipe_pkg::ctrl_pc_t         ctrl_pc_o,
    output logic                       send_inst1_en_o
);
    import csr_pkg::*;

    csr_word_u           fwd_word;
    logic                hit_crmd;
    logic                hit_ecfg;
    logic                hit_estat;
    logic                hit_era;
    logic                hit_eentry;
    logic [31:0]         era_cur;
    logic [31:0]         eentry_cur;
    logic [11:0]         lie_cur;
    logic [11:0]         is_cur;
    logic                ie_cur;
    logic [11:0]         int_vec;
    logic [5:0]          cause;
    logic                has_cause;
    logic                pause_idle;
    logic [`PAUSE_W-1:0] pause_mask;

    ////////////////////////////////////////////////////////////////////////////
    // forwarding of the write-back write
    ////////////////////////////////////////////////////////////////////////////

    assign fwd_word = wb_push_i.csr_write_data;

    assign hit_crmd   = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_CRMD);
    assign hit_ecfg   = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_ECFG);
    assign hit_estat  = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_ESTAT);
    assign hit_era    = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_ERA);
    assign hit_eentry = wb_push_i.csr_write_en && (wb_push_i.csr_write_addr == `CSR_EENTRY);

    assign era_cur    = hit_era    ? wb_push_i.csr_write_data : csr_view_i.era_pc;
    assign eentry_cur = hit_eentry ? wb_push_i.csr_write_data : csr_view_i.eentry_va;
    assign lie_cur    = hit_ecfg   ? pack_int(fwd_word.intr.bits) : csr_view_i.ecfg_lie;
    assign is_cur     = hit_estat  ? pack_int(fwd_word.intr.bits) : csr_view_i.estat_is;
    assign ie_cur     = hit_crmd   ? fwd_word.crmd.ie : csr_view_i.crmd_ie;

    ////////////////////////////////////////////////////////////////////////////
    // interrupt, exception and redirect
    ////////////////////////////////////////////////////////////////////////////

    assign int_vec       = ie_cur ? (lie_cur & is_cur) : 12'b0;
    assign int_pending_o = |int_vec;

    // later slots win.
    always_comb begin
        cause = `EXC_NOP;
        for (int i = 0; i < `EXC_SLOTS; i++) begin
            if (mem_i.is_exception[i]) begin
                cause = mem_i.exception_cause[i];
            end
        end
    end

    assign has_cause = (mem_i.pc != 32'h0000_00fc) && (|mem_i.is_exception); // skip reset bubble.

    assign exc_report_o.is_exception    = has_cause;
    assign exc_report_o.is_ertn         = mem_i.is_ertn;
    assign exc_report_o.exception_cause = has_cause ? cause : `EXC_NOP;
    assign exc_report_o.exception_pc    = mem_i.pc;
    assign exc_report_o.exception_addr  = mem_i.exception_addr;

    assign ctrl_pc_o.exception_new_pc = mem_i.is_ertn ? era_cur : eentry_cur;
    assign ctrl_pc_o.is_interrupt     = int_pending_o;
    assign ctrl_o.exception_flush     = (|mem_i.is_exception) || mem_i.is_ertn;

    ////////////////////////////////////////////////////////////////////////////
    // pause mask
    ////////////////////////////////////////////////////////////////////////////

    assign pause_idle = mem_i.is_idle && !int_pending_o && !continue_idle_i;

    always_comb begin
        if (pause_i.pause_if) begin
            pause_mask = 'h01;
        end else if (pause_i.pause_id) begin
            pause_mask = 'h0f;
        end else if (pause_i.pause_dispatch) begin
            pause_mask = 'h1f;
        end else if (pause_i.pause_ex) begin
            pause_mask = 'h3f;
        end else if (pause_i.pause_mem || pause_idle) begin
            pause_mask = 'h7f;                  // idle holds up to mem.
        end else begin
            pause_mask = '0;
        end
    end

    assign ctrl_o.pause     = pause_mask;
    assign send_inst1_en_o  = !pause_mask[`PAUSE_IBUF];

endmodule

//--- ctrl/idle_wake.sv
`timescale 1ns/1ps

module idle_wake (
    input  logic clk,
    input  logic arst_n_i,
    input  logic is_idle_i,
    input  logic int_pending_i,
    output logic continue_idle_o
);

    logic wake_q;

    // once woken, the idle stays released until it leaves mem,
    // even if the interrupt source is cleared first
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wake_q <= 1'b0;
        end else if (!is_idle_i) begin
            wake_q <= 1'b0;                 // idle gone.
        end else if (int_pending_i) begin
            wake_q <= 1'b1;
        end
    end

    assign continue_idle_o = wake_q;

endmodule

//--- rtl/ctrl_unit_top.sv
`timescale 1ns/1ps

module ctrl_unit_top (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  pipe_pkg::pause_t           pause_i,
    input  pipe_pkg::mem_ctrl_t        mem_i,
    input  csr_pkg::csr_push_forward_t wb_push_i,
    input  logic [7:0]                 int_lines_i,
    input  logic [13:0]                rd_addr_i,
    output logic [31:0]                rd_data_o,
    output pipe_pkg::ctrl_t            ctrl_o,
    output pipe_pkg::ctrl_pc_t         ctrl_pc_o,
    output logic                       send_inst1_en_o
);
    import csr_pkg::*;

    csr_view_t   csr_view;
    exc_report_t exc_report;
    logic        int_pending;
    logic        continue_idle;

    csr_regs u_csr_regs (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .wb_push_i    (wb_push_i),
        .exc_report_i (exc_report),
        .int_lines_i  (int_lines_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .csr_view_o   (csr_view)
    );

    exc_ctrl u_exc_ctrl (
        .pause_i         (pause_i),
        .mem_i           (mem_i),
        .wb_push_i       (wb_push_i),
        .csr_view_i      (csr_view),
        .continue_idle_i (continue_idle),
        .exc_report_o    (exc_report),
        .int_pending_o   (int_pending),
        .ctrl_o          (ctrl_o),
        .ctrl_pc_o       (ctrl_pc_o),
        .send_inst1_en_o (send_inst1_en_o)
    );

    idle_wake u_idle_wake (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .is_idle_i       (mem_i.is_idle),
        .int_pending_i   (int_pending),
        .continue_idle_o (continue_idle)
    );

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;                    // release away from the rising edge.
    end

endmodule

//--- verification/tb_ctrl_unit.sv
`timescale 1ns/1ps

module tb_ctrl_unit;
    import pipe_pkg::*;
    import csr_pkg::*;

    localparam int    TIMEOUT_CYCLES = 1000;
    localparam int    MAX_LINES      = 1000;
    localparam int    SETTLE_NS      = 3;     // one ns before the next rising edge.
    localparam string TRACE_FILE     = "verification/ctrl_unit_trace.txt";

    logic              clk;
    logic              arst_n;
    pause_t            pause;
    mem_ctrl_t         mem;
    csr_push_forward_t wb_push;
    logic [7:0]        int_lines;
    logic [13:0]       rd_addr;
    logic [31:0]       rd_data;
    ctrl_t             ctrl;
    ctrl_pc_t          ctrl_pc;
    logic              send_inst1_en;

    int value_errors;
    int other_errors;
    int checks;

    clk_gen u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    ctrl_unit_top dut0 (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .pause_i         (pause),
        .mem_i           (mem),
        .wb_push_i       (wb_push),
        .int_lines_i     (int_lines),
        .rd_addr_i       (rd_addr),
        .rd_data_o       (rd_data),
        .ctrl_o          (ctrl),
        .ctrl_pc_o       (ctrl_pc),
        .send_inst1_en_o (send_inst1_en)
    );

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected flush=%0b pause=%h, actual flush=%0b pause=%h",
                     $time, name, exp.exception_flush, exp.pause,
                     act.exception_flush, act.pause);
        end
    endtask

    task automatic check_pc(input string name, input ctrl_pc_t exp, input ctrl_pc_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected new_pc=%h int=%0b, actual new_pc=%h int=%0b",
                     $time, name, exp.exception_new_pc, exp.is_interrupt,
                     act.exception_new_pc, act.is_interrupt);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_idle();
        pause     = '0;
        mem       = '0;
        wb_push   = '0;
        int_lines = '0;
        rd_addr   = '0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!arst_n && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!arst_n) begin
            other_errors++;
            $display("Error: reset still asserted after %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    // one trace line per cycle, driven on the falling edge
    task automatic run_trace();
        int           fd;
        int           rc;
        int           fields;
        int           line_no;
        int           vectors;
        string        line;
        logic [4:0]   t_pause;
        logic [31:0]  t_pc;
        logic [5:0]   t_exc;
        logic [35:0]  t_causes;
        logic         t_ertn;
        logic         t_idle;
        logic         t_wen;
        logic [13:0]  t_waddr;
        logic [31:0]  t_wdata;
        logic [7:0]   t_ints;
        logic [13:0]  t_rd;
        logic         e_flush;
        logic [7:0]   e_pause;
        logic [31:0]  e_newpc;
        logic         e_int;
        logic         e_send;
        logic [31:0]  e_rd;
        ctrl_t        exp_ctrl;
        ctrl_pc_t     exp_pc;

        line_no = 0;
        vectors = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Error: cannot open the trace file %s", TRACE_FILE);
            return;
        end
        while (!$feof(fd) && line_no < MAX_LINES) begin
            rc = $fgets(line, fd);
            line_no++;
            if (rc <= 1 || line.getc(0) == "#") begin
                continue;                   // blank or comment.
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             t_pause, t_pc, t_exc, t_causes, t_ertn, t_idle,
                             t_wen, t_waddr, t_wdata, t_ints, t_rd,
                             e_flush, e_pause, e_newpc, e_int, e_send, e_rd);
            if (fields != 17) begin
                other_errors++;
                $display("Error: trace line %0d is malformed, %0d fields found",
                         line_no, fields);
                continue;
            end
            vectors++;

            @(negedge clk);
            pause                  = t_pause;
            mem                    = '0;
            mem.pc                 = t_pc;
            mem.is_exception       = t_exc;
            mem.exception_cause    = t_causes;
            mem.exception_addr     = t_pc;
            mem.is_ertn            = t_ertn;
            mem.is_idle            = t_idle;
            wb_push.csr_write_en   = t_wen;
            wb_push.csr_write_addr = t_waddr;
            wb_push.csr_write_data = t_wdata;
            int_lines              = t_ints;
            rd_addr                = t_rd;

            exp_ctrl.exception_flush = e_flush;
            exp_ctrl.pause           = e_pause;
            exp_pc.exception_new_pc  = e_newpc;
            exp_pc.is_interrupt      = e_int;

            #SETTLE_NS;
            check_ctrl("ctrl_o", exp_ctrl, ctrl);
            check_pc("ctrl_pc_o", exp_pc, ctrl_pc);
            check_word("send_inst1_en_o", {31'b0, e_send}, {31'b0, send_inst1_en});
            check_word("rd_data_o", e_rd, rd_data);
        end
        if (!$feof(fd)) begin
            other_errors++;
            $display("Error: trace file longer than %0d lines", MAX_LINES);
        end
        if (vectors == 0) begin
            other_errors++;
            $display("Error: trace file holds no vectors");
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        value_errors = 0;
        other_errors = 0;
        checks       = 0;
        drive_idle();
        wait_reset_release();
        if (other_errors == 0) begin
            run_trace();
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verification/ctrl_unit_trace.txt
# inputs: pause(if,id,dispatch,ex,mem) pc exc_mask causes(slot5..0) ertn idle wen waddr wdata ints rd_addr
# expected: flush pause_mask new_pc is_interrupt send_inst1_en rd_data
00 00000000 00 000000000 0 0 0 000 00000000 00 000 0 00 00000000 0 1 00000000
10 00000000 00 000000000 0 0 0 000 00000000 00 000 0 01 00000000 0 1 00000000
08 00000000 00 000000000 0 0 0 000 00000000 00 000 0 0f 00000000 0 0 00000000
04 00000000 00 000000000 0 0 0 000 00000000 00 000 0 1f 00000000 0 0 00000000
02 00000000 00 000000000 0 0 0 000 00000000 00 000 0 3f 00000000 0 0 00000000
01 00000000 00 000000000 0 0 0 000 00000000 00 000 0 7f 00000000 0 0 00000000
18 00000000 00 000000000 0 0 0 000 00000000 00 000 0 01 00000000 0 1 00000000
0c 00000000 00 000000000 0 0 0 000 00000000 00 000 0 0f 00000000 0 0 00000000
06 00000000 00 000000000 0 0 0 000 00000000 00 000 0 1f 00000000 0 0 00000000
03 00000000 00 000000000 0 0 0 000 00000000 00 000 0 3f 00000000 0 0 00000000
1f 00000000 00 000000000 0 0 0 000 00000000 00 000 0 01 00000000 0 1 00000000
05 00000000 00 000000000 0 0 0 000 00000000 00 000 0 1f 00000000 0 0 00000000
00 00000000 00 000000000 0 0 1 00c 1c000000 00 00c 0 00 1c000000 0 1 00000000
00 00000000 00 000000000 0 0 0 000 00000000 00 00c 0 00 1c000000 0 1 1c000000
00 1c000100 05 00000b008 0 0 0 000 00000000 00 005 1 00 1c000000 0 1 00000000
00 00000000 00 000000000 0 0 0 000 00000000 00 005 0 00 1c000000 0 1 000b0000
00 00000000 00 000000000 0 0 0 000 00000000 00 006 0 00 1c000000 0 1 1c000100
00 1c000200 22 680000040 0 0 0 000 00000000 00 005 1 00 1c000000 0 1 000b0000
00 00000000 00 000000000 0 0 0 000 00000000 00 005 0 00 1c000000 0 1 001a0000
00 000000fc 01 000000003 0 0 0 000 00000000 00 006 1 00 1c000000 0 1 1c000200
00 00000000 00 000000000 0 0 0 000 00000000 00 005 0 00 1c000000 0 1 001a0000
00 00000000 00 000000000 0 0 0 000 00000000 00 006 0 00 1c000000 0 1 1c000200
00 1c000300 01 00000000c 0 0 1 00c 1c008000 00 00c 1 00 1c008000 0 1 1c000000
00 00000000 00 000000000 0 0 0 000 00000000 00 00c 0 00 1c008000 0 1 1c008000
00 00000000 00 000000000 0 0 1 004 00000004 00 004 0 00 1c008000 0 1 00000000
00 00000000 00 000000000 0 0 1 000 00000004 01 004 0 00 1c008000 0 1 00000004
00 00000000 00 000000000 0 0 0 000 00000000 01 000 0 00 1c008000 1 1 00000004
00 00000000 00 000000000 0 0 1 000 00000000 01 000 0 00 1c008000 0 1 00000004
00 00000000 00 000000000 0 0 1 000 00000004 01 000 0 00 1c008000 1 1 00000000
00 00000000 00 000000000 0 0 1 004 00000000 01 005 0 00 1c008000 0 1 000c0004
00 00000000 00 000000000 0 0 0 000 00000000 01 004 0 00 1c008000 0 1 00000000
00 1c000400 01 000000005 0 0 0 000 00000000 01 000 1 00 1c008000 0 1 00000004
00 00000000 00 000000000 0 0 0 000 00000000 01 000 0 00 1c008000 0 1 00000008
00 00000000 00 000000000 0 0 0 000 00000000 01 006 0 00 1c008000 0 1 1c000400
00 00000000 00 000000000 1 0 0 000 00000000 01 000 1 00 1c000400 0 1 00000008
00 00000000 00 000000000 0 0 0 000 00000000 01 000 0 00 1c008000 0 1 0000000c
00 00000000 00 000000000 0 1 1 004 00000008 00 004 0 7f 1c008000 0 0 00000000
00 00000000 00 000000000 0 1 0 000 00000000 02 004 0 7f 1c008000 0 0 00000008
00 00000000 00 000000000 0 1 0 000 00000000 00 005 0 00 1c008000 1 1 00050008
00 00000000 00 000000000 0 1 0 000 00000000 00 005 0 00 1c008000 0 1 00050000
00 00000000 00 000000000 0 1 0 000 00000000 00 005 0 00 1c008000 0 1 00050000
00 00000000 00 000000000 0 0 0 000 00000000 00 005 0 00 1c008000 0 1 00050000
00 00000000 00 000000000 0 1 0 000 00000000 00 000 0 7f 1c008000 0 0 0000000c
00 00000000 00 000000000 0 0 0 000 00000000 00 000 0 00 1c008000 0 1 0000000c

//--- ctrl_unit.f
+incdir+common
common/pipe_pkg.sv
common/csr_pkg.sv
csr/csr_regs.sv
ctrl/exc_ctrl.sv
ctrl/idle_wake.sv
rtl/ctrl_unit_top.sv
verification/clk_gen.sv
verification/tb_ctrl_unit.sv
